// File: uhdl_mem_cfg.svh
// Memory subsystem sizes
`ifndef UHDL_MEM_CFG_SVH
`define UHDL_MEM_CFG_SVH

// Shared word store
`define UHDL_MEM_AW 12       // 4096 store words
`define UHDL_WORD_W 32       // Store word width

// Port address widths, scaled down from the full machine
`define UHDL_SDRAM_AW 10     // Main memory words
`define UHDL_VRAM_AW 10      // Video memory words
`define UHDL_MCR_AW 9        // Microcode words, two store words each

// Region bases in store words
`define UHDL_SDRAM_BASE 0    // Main memory region
`define UHDL_VRAM_BASE 1024  // Shared by video CPU and VGA refresh
`define UHDL_MCR_BASE 2048   // Microcode region, 1024 store words

// Microcode word
`define UHDL_MCR_W 49        // Low 32 bits in the first store word

`endif

// File: uhdl_mem_pkg.sv
// Memory subsystem types
package uhdl_mem_pkg;

`include "uhdl_mem_cfg.svh"

   // One store word
   typedef logic [`UHDL_WORD_W-1:0] word_t;

   // Store address, region base included
   typedef logic [`UHDL_MEM_AW-1:0] phys_addr_t;

   // Microcode word, spans two store words
   typedef logic [`UHDL_MCR_W-1:0] mcr_word_t;

   // Requesters of the store, and no owner
   typedef enum logic [2:0] {
      PORT_NONE,   // Bus free
      PORT_VGA,    // Refresh read, highest priority
      PORT_MCR,    // Microcode
      PORT_VRAM,   // Video memory from the CPU
      PORT_SDRAM   // Main memory, lowest priority
   } port_id_e;

   // Arbiter sequencing
   typedef enum logic [1:0] {
      ARB_IDLE,    // Pick an owner
      ARB_BEAT,    // Grant one beat per cycle
      ARB_WAIT,    // Last read data returns
      ARB_DONE     // Settle before next pick
   } arb_state_e;

endpackage

// File: mem_beat_if.sv
// Port to arbiter beat link
`timescale 1ns/1ps

interface mem_beat_if;
   import uhdl_mem_pkg::*;

   // Port side
   logic       pending;  // Beat waiting for the store
   logic       write;    // Beat writes wdata
   phys_addr_t addr;     // Store address of this beat
   word_t      wdata;    // Write data of this beat
   logic       last;     // Final beat of the transfer

   // Arbiter side
   logic       grant;    // Beat taken this cycle
   logic       rvalid;   // Beat result, one cycle after grant
   word_t      rdata;    // Store data for read beats

   // Requesting end
   modport port (
      output pending, write, addr, wdata, last,
      input  grant, rvalid, rdata
   );

   // Serving end
   modport arb (
      input  pending, write, addr, wdata, last,
      output grant, rvalid, rdata
   );

endinterface

// File: req_port.sv
// Requester port datapath
`timescale 1ns/1ps
`include "uhdl_mem_cfg.svh"

module req_port #(
   parameter type data_t      = uhdl_mem_pkg::word_t,
   parameter int  REGION_BASE = 0
) (
   input  logic                    uhdl_common,
   input  logic                    rst_n,
   input  logic                    req,
   input  logic                    write,
   input  uhdl_mem_pkg::phys_addr_t addr,
   input  data_t                   data_in,
   output data_t                   data_out,
   output logic                    ready,
   output logic                    done,
   mem_beat_if.port                beat
);
   import uhdl_mem_pkg::*;

   localparam int DW    = $bits(data_t);
   localparam int WW    = `UHDL_WORD_W;
   localparam int BEATS = (DW + WW - 1) / WW;      // Store words per payload
   localparam int PW    = BEATS * WW;              // Payload padded to whole words
   localparam int CW    = (BEATS > 1) ? $clog2(BEATS) : 1;

   logic          busy_q;                          // Request in flight
   logic          pending_q;                       // Beats left to grant
   logic          write_q;
   logic [CW-1:0] gcnt_q;                          // Beats granted
   logic [CW-1:0] rcnt_q;                          // Beats returned
   phys_addr_t    addr_q;                          // Address of next beat
   logic [PW-1:0] wr_q;                            // Write words, low first
   logic [PW-1:0] rd_q;                            // Read words gathered so far
   logic [PW-1:0] rd_next;

   // Newest read word enters at the top
   assign rd_next = (rd_q >> WW) | (PW'(beat.rdata) << (PW - WW));

   assign beat.pending = pending_q;
   assign beat.write   = write_q;
   assign beat.addr    = addr_q;
   assign beat.wdata   = wr_q[WW-1:0];                 // Current word
   assign beat.last    = (gcnt_q == CW'(BEATS - 1));

   always_ff @(posedge uhdl_common or negedge rst_n) begin
      if (!rst_n) begin
         busy_q    <= 1'b0;
         pending_q <= 1'b0;
         write_q   <= 1'b0;
         ready     <= 1'b0;
         done      <= 1'b0;
         gcnt_q    <= '0;
         rcnt_q    <= '0;
      end else begin
         ready <= 1'b0;
         done  <= 1'b0;
         if (req && !busy_q) begin                 // Capture while idle
            busy_q    <= 1'b1;
            pending_q <= 1'b1;
            write_q   <= write;
            ready     <= 1'b1;
            gcnt_q    <= '0;
            rcnt_q    <= '0;
         end
         if (beat.grant) begin
            gcnt_q <= gcnt_q + 1'b1;
            if (beat.last) pending_q <= 1'b0;       // No more beats to offer
         end
         if (beat.rvalid) begin
            rcnt_q <= rcnt_q + 1'b1;
            if (rcnt_q == CW'(BEATS - 1)) begin     // Final result back
               busy_q <= 1'b0;
               done   <= 1'b1;
            end
         end
      end
   end

   // Payload path
   always_ff @(posedge uhdl_common) begin
      if (req && !busy_q) begin
         addr_q <= phys_addr_t'(REGION_BASE) + phys_addr_t'(addr * BEATS);
         wr_q   <= PW'(data_in);
      end else if (beat.grant) begin
         addr_q <= addr_q + 1'b1;                   // Next store word
         wr_q   <= wr_q >> WW;
      end
      if (beat.rvalid) begin
         rd_q <= rd_next;
         if (!write_q && rcnt_q == CW'(BEATS - 1))
            data_out <= rd_next[DW-1:0];            // Held until next read
      end
   end

endmodule

// File: mem_arbiter.sv
// Fixed priority store arbiter
`timescale 1ns/1ps

module mem_arbiter (
   input  logic                     uhdl_common,
   input  logic                     rst_n,
   mem_beat_if.arb                  mcr_p,
   mem_beat_if.arb                  vram_p,
   mem_beat_if.arb                  sdram_p,
   input  logic                     vga_req,
   input  uhdl_mem_pkg::phys_addr_t vga_addr,
   output uhdl_mem_pkg::word_t      vga_data,
   output logic                     vga_ready,
   output uhdl_mem_pkg::phys_addr_t mem_addr,
   output logic                     mem_we,
   output uhdl_mem_pkg::word_t      mem_wdata,
   input  uhdl_mem_pkg::word_t      mem_rdata
);
   import uhdl_mem_pkg::*;

   arb_state_e state_q, state_d;
   port_id_e   owner_q, owner_d;    // Holds the bus from pick to settle
   logic       issued_q;            // A beat went to the store last cycle

   phys_addr_t own_addr;
   word_t      own_wdata;
   logic       own_write;
   logic       own_last;

   // Next owner and state
   always_comb begin
      state_d = state_q;
      owner_d = owner_q;
      case (state_q)
         ARB_IDLE: begin
            if (vga_req)              owner_d = PORT_VGA;    // Refresh first
            else if (mcr_p.pending)   owner_d = PORT_MCR;
            else if (vram_p.pending)  owner_d = PORT_VRAM;
            else if (sdram_p.pending) owner_d = PORT_SDRAM;
            else                      owner_d = PORT_NONE;
            if (owner_d != PORT_NONE) state_d = ARB_BEAT;
         end
         ARB_BEAT: begin
            if (own_last) state_d = ARB_WAIT;   // Back to back until last
         end
         ARB_WAIT: begin
            state_d = ARB_DONE;                 // Last result returning
         end
         ARB_DONE: begin
            state_d = ARB_IDLE;
            owner_d = PORT_NONE;                // Release the bus
         end
         default: begin
            state_d = ARB_IDLE;
            owner_d = PORT_NONE;
         end
      endcase
   end

   // Beat of the current owner
   always_comb begin
      own_addr  = vga_addr;                     // VGA reads only
      own_wdata = '0;
      own_write = 1'b0;
      own_last  = 1'b1;                         // VGA is a single beat
      case (owner_q)
         PORT_MCR: begin
            own_addr  = mcr_p.addr;
            own_wdata = mcr_p.wdata;
            own_write = mcr_p.write;
            own_last  = mcr_p.last;
         end
         PORT_VRAM: begin
            own_addr  = vram_p.addr;
            own_wdata = vram_p.wdata;
            own_write = vram_p.write;
            own_last  = vram_p.last;
         end
         PORT_SDRAM: begin
            own_addr  = sdram_p.addr;
            own_wdata = sdram_p.wdata;
            own_write = sdram_p.write;
            own_last  = sdram_p.last;
         end
         default: ;
      endcase
   end

   always_ff @(posedge uhdl_common or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= ARB_IDLE;
         owner_q  <= PORT_NONE;
         issued_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         owner_q  <= owner_d;
         issued_q <= (state_q == ARB_BEAT);     // Store data due next cycle
      end
   end

   // Store side
   assign mem_addr  = own_addr;
   assign mem_wdata = own_wdata;
   assign mem_we    = (state_q == ARB_BEAT) && own_write;

   // Grants, one per beat cycle
   assign mcr_p.grant   = (state_q == ARB_BEAT) && (owner_q == PORT_MCR);
   assign vram_p.grant  = (state_q == ARB_BEAT) && (owner_q == PORT_VRAM);
   assign sdram_p.grant = (state_q == ARB_BEAT) && (owner_q == PORT_SDRAM);

   // Results, owner unchanged until settle
   assign mcr_p.rvalid   = issued_q && (owner_q == PORT_MCR);
   assign vram_p.rvalid  = issued_q && (owner_q == PORT_VRAM);
   assign sdram_p.rvalid = issued_q && (owner_q == PORT_SDRAM);
   assign mcr_p.rdata    = mem_rdata;
   assign vram_p.rdata   = mem_rdata;
   assign sdram_p.rdata  = mem_rdata;
   assign vga_ready      = issued_q && (owner_q == PORT_VGA);
   assign vga_data       = mem_rdata;

endmodule

// File: sram_bank.sv
// On-chip word store
`timescale 1ns/1ps
`include "uhdl_mem_cfg.svh"

module sram_bank (
   input  logic                     uhdl_common,
   input  uhdl_mem_pkg::phys_addr_t addr,
   input  logic                     we,
   input  uhdl_mem_pkg::word_t      wdata,
   output uhdl_mem_pkg::word_t      rdata
);
   import uhdl_mem_pkg::*;

   localparam int DEPTH = 2 ** `UHDL_MEM_AW;   // 4096 words

   // Regions for main memory, video and microcode share this array
   word_t mem [0:DEPTH-1];

   // Write lands at the closing edge
   always_ff @(posedge uhdl_common) begin
      if (we)
         mem[addr] <= wdata;
   end

   // Registered read, old data on a same-cycle write
   always_ff @(posedge uhdl_common) begin
      rdata <= mem[addr];
   end

endmodule

// File: ram_controller.sv
// Shared memory controller
`timescale 1ns/1ps
`include "uhdl_mem_cfg.svh"

module ram_controller (
   input  logic                       uhdl_common,
   input  logic                       rst_n,
   // Main memory
   input  logic                       sdram_req,
   input  logic                       sdram_write,
   input  logic [`UHDL_SDRAM_AW-1:0]  sdram_addr,
   input  logic [`UHDL_WORD_W-1:0]    sdram_data_in,
   output logic [`UHDL_WORD_W-1:0]    sdram_data_out,
   output logic                       sdram_ready,
   output logic                       sdram_done,
   // Video memory, CPU side
   input  logic                       vram_cpu_req,
   input  logic                       vram_cpu_write,
   input  logic [`UHDL_VRAM_AW-1:0]   vram_cpu_addr,
   input  logic [`UHDL_WORD_W-1:0]    vram_cpu_data_in,
   output logic [`UHDL_WORD_W-1:0]    vram_cpu_data_out,
   output logic                       vram_cpu_ready,
   output logic                       vram_cpu_done,
   // Microcode
   input  logic                       mcr_req,
   input  logic                       mcr_write,
   input  logic [`UHDL_MCR_AW-1:0]    mcr_addr,
   input  uhdl_mem_pkg::mcr_word_t    mcr_data_in,
   output uhdl_mem_pkg::mcr_word_t    mcr_data_out,
   output logic                       mcr_ready,
   output logic                       mcr_done,
   // Refresh reads
   input  logic                       vram_vga_req,
   input  logic [`UHDL_VRAM_AW-1:0]   vram_vga_addr,
   output logic [`UHDL_WORD_W-1:0]    vram_vga_data_out,
   output logic                       vram_vga_ready
);
   import uhdl_mem_pkg::*;

   mem_beat_if sdram_beat ();
   mem_beat_if vram_beat ();
   mem_beat_if mcr_beat ();

   phys_addr_t vga_phys;      // Refresh address in the video region
   phys_addr_t mem_addr;
   logic       mem_we;
   word_t      mem_wdata;
   word_t      mem_rdata;

   assign vga_phys = phys_addr_t'(`UHDL_VRAM_BASE) + phys_addr_t'(vram_vga_addr);

   req_port #(.data_t(word_t), .REGION_BASE(`UHDL_SDRAM_BASE)) sdram_port_inst (
      .uhdl_common, .rst_n, .req(sdram_req), .write(sdram_write),
      .addr(phys_addr_t'(sdram_addr)), .data_in(sdram_data_in),
      .data_out(sdram_data_out), .ready(sdram_ready), .done(sdram_done),
      .beat(sdram_beat.port));

   req_port #(.data_t(word_t), .REGION_BASE(`UHDL_VRAM_BASE)) vram_port_inst (
      .uhdl_common, .rst_n, .req(vram_cpu_req), .write(vram_cpu_write),
      .addr(phys_addr_t'(vram_cpu_addr)), .data_in(vram_cpu_data_in),
      .data_out(vram_cpu_data_out), .ready(vram_cpu_ready), .done(vram_cpu_done),
      .beat(vram_beat.port));

   req_port #(.data_t(mcr_word_t), .REGION_BASE(`UHDL_MCR_BASE)) mcr_port_inst (
      .uhdl_common, .rst_n, .req(mcr_req), .write(mcr_write),
      .addr(phys_addr_t'(mcr_addr)), .data_in(mcr_data_in),
      .data_out(mcr_data_out), .ready(mcr_ready), .done(mcr_done),
      .beat(mcr_beat.port));     // Two beats per word

   mem_arbiter mem_arbiter_inst (
      .uhdl_common, .rst_n,
      .mcr_p(mcr_beat.arb), .vram_p(vram_beat.arb), .sdram_p(sdram_beat.arb),
      .vga_req(vram_vga_req), .vga_addr(vga_phys),
      .vga_data(vram_vga_data_out), .vga_ready(vram_vga_ready),
      .mem_addr, .mem_we, .mem_wdata, .mem_rdata);

   sram_bank sram_bank_inst (
      .uhdl_common, .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .rdata(mem_rdata));

endmodule

// File: tb_ram_controller.sv
// Memory controller testbench
`timescale 1ns/1ps
`include "uhdl_mem_cfg.svh"

module tb_ram_controller;
   localparam int MAX_OPS = 64;

   logic                      uhdl_common;
   logic                      rst_n;
   logic                      sdram_req, sdram_write, sdram_ready, sdram_done;
   logic [`UHDL_SDRAM_AW-1:0] sdram_addr;
   logic [`UHDL_WORD_W-1:0]   sdram_data_in, sdram_data_out;
   logic                      vram_cpu_req, vram_cpu_write, vram_cpu_ready, vram_cpu_done;
   logic [`UHDL_VRAM_AW-1:0]  vram_cpu_addr, vram_vga_addr;
   logic [`UHDL_WORD_W-1:0]   vram_cpu_data_in, vram_cpu_data_out, vram_vga_data_out;
   logic                      mcr_req, mcr_write, mcr_ready, mcr_done;
   logic [`UHDL_MCR_AW-1:0]   mcr_addr;
   logic [`UHDL_MCR_W-1:0]    mcr_data_in, mcr_data_out;
   logic                      vram_vga_req, vram_vga_ready;

   logic [7:0]  op_code [MAX_OPS];     // W, R or C
   logic [7:0]  op_port [MAX_OPS];     // S, V, M or G
   logic [15:0] op_addr [MAX_OPS];     // Port word address
   logic [63:0] op_data [MAX_OPS];
   logic [63:0] op_exp  [MAX_OPS];
   int          fin_cyc [MAX_OPS];     // Cycle of done or of VGA ready
   int          n_ops;
   int          errors;
   int          limit;
   int          cycle = 0;

   ram_controller ram_controller_inst (.*);

   always #4 uhdl_common = ~uhdl_common;   // 8 ns period

   // Watchdog with its limit set once the table is loaded
   always @(posedge uhdl_common) begin
      cycle <= cycle + 1;
      if (limit > 0 && cycle >= limit) begin
         $display("ERROR: timeout, tests did not finish within %0d cycles", limit);
         $display("errors: %0d, timeouts: 1", errors);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (act !== exp) begin
         errors++;
         $display("mismatch %s: expected %h actual %h", name, exp, act);
      end
   endtask

   // Request lines of one port
   task automatic drive_req(input logic [7:0] p, input logic on, input logic wr,
                            input logic [15:0] a, input logic [63:0] d);
      case (p)
         "S": begin
            sdram_req     = on;
            sdram_write   = wr;
            sdram_addr    = a[`UHDL_SDRAM_AW-1:0];
            sdram_data_in = d[`UHDL_WORD_W-1:0];
         end
         "V": begin
            vram_cpu_req     = on;
            vram_cpu_write   = wr;
            vram_cpu_addr    = a[`UHDL_VRAM_AW-1:0];
            vram_cpu_data_in = d[`UHDL_WORD_W-1:0];
         end
         "M": begin
            mcr_req     = on;
            mcr_write   = wr;
            mcr_addr    = a[`UHDL_MCR_AW-1:0];
            mcr_data_in = d[`UHDL_MCR_W-1:0];
         end
         default: begin
            vram_vga_req  = on;              // Read only
            vram_vga_addr = a[`UHDL_VRAM_AW-1:0];
         end
      endcase
   endtask

   // Ready or done; VGA has ready only
   function automatic logic port_flag(input logic [7:0] p, input bit want_done);
      case (p)
         "S":     return want_done ? sdram_done : sdram_ready;
         "V":     return want_done ? vram_cpu_done : vram_cpu_ready;
         "M":     return want_done ? mcr_done : mcr_ready;
         default: return vram_vga_ready;
      endcase
   endfunction

   function automatic logic [63:0] port_data(input logic [7:0] p);
      case (p)
         "S":     return 64'(sdram_data_out);
         "V":     return 64'(vram_cpu_data_out);
         "M":     return 64'(mcr_data_out);
         default: return 64'(vram_vga_data_out);
      endcase
   endfunction

   // Store access order with VGA served first
   function automatic int grant_rank(input logic [7:0] p);
      case (p)
         "G":     return 0;
         "M":     return 1;
         "V":     return 2;
         default: return 3;                // Main memory last
      endcase
   endfunction

   // Sampled mid-cycle away from the edge
   task automatic wait_flag(input logic [7:0] p, input bit want_done);
      do begin
         @(negedge uhdl_common);
      end while (!port_flag(p, want_done));
   endtask

   task automatic read_tests();
      int               fd;
      int               cnt;
      logic [8*128-1:0] text;
      logic [7:0]       c_op, c_port;
      logic [15:0]      c_addr;
      logic [63:0]      c_data, c_exp;
      fd = $fopen("test_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("ERROR: cannot open test_input.txt");
      end else begin
         while (!$feof(fd) && n_ops < MAX_OPS) begin
            text = '0;
            cnt  = $fgets(text, fd);
            cnt  = $sscanf(text, "%s %s %h %h %h", c_op, c_port, c_addr, c_data, c_exp);
            if (cnt == 5 && c_op inside {"W", "R", "C"} &&
                c_port inside {"S", "V", "M", "G"}) begin
               op_code[n_ops] = c_op;
               op_port[n_ops] = c_port;
               op_addr[n_ops] = c_addr;
               op_data[n_ops] = c_data;
               op_exp[n_ops]  = c_exp;
               n_ops++;
            end                              // Comment and blank lines fall out here
         end
         $fclose(fd);
      end
      if (n_ops == 0) begin
         errors++;
         $display("ERROR: no operations read from test_input.txt");
      end
   endtask

   // One line; hold keeps req high through the access as a second request
   task automatic run_op(input int i, input bit hold);
      string      name;
      logic [7:0] p;
      bit         wr;
      bit         early;
      name  = $sformatf("line%0d_%c%c", i + 1, op_code[i], op_port[i]);
      p     = op_port[i];
      wr    = (op_code[i] == "W");
      early = 1'b0;
      @(posedge uhdl_common);
      #1;
      drive_req(p, 1'b1, wr, op_addr[i], op_data[i]);
      wait_flag(p, 1'b0);
      if (p == "G") begin
         fin_cyc[i] = cycle;                 // VGA data valid with ready
         check_value(name, op_exp[i], port_data(p));
      end
      if (hold) begin
         do begin
            @(negedge uhdl_common);
            if (port_flag(p, 1'b0)) early = 1'b1;
         end while (!port_flag(p, 1'b1));
         check_value(name, op_exp[i], port_data(p));
         check_value({name, "_early_ready"}, 64'd0, 64'(early));
         wait_flag(p, 1'b0);                 // Second request taken after done
         name = {name, "_repeat"};
      end
      @(posedge uhdl_common);
      #1;
      drive_req(p, 1'b0, wr, op_addr[i], op_data[i]);
      if (p != "G") begin
         wait_flag(p, 1'b1);
         fin_cyc[i] = cycle;
         if (!wr) check_value(name, op_exp[i], port_data(p));
      end
   endtask

   // Four C lines issued in one cycle
   task automatic run_group(input int i);
      bit ordered;
      ordered = 1'b1;
      if (i + 3 >= n_ops) begin
         errors++;
         $display("ERROR: concurrent group at line %0d has fewer than four lines", i + 1);
      end else begin
         fork
            run_op(i, 1'b0);
            run_op(i + 1, 1'b0);
            run_op(i + 2, 1'b0);
            run_op(i + 3, 1'b0);
         join
         for (int k = i; k < i + 4; k++)
            for (int j = i; j < i + 4; j++)
               if (grant_rank(op_port[k]) < grant_rank(op_port[j]) &&
                   fin_cyc[k] >= fin_cyc[j])
                  ordered = 1'b0;            // Higher priority must finish first
         check_value($sformatf("line%0d_priority_order", i + 1), 64'd1, 64'(ordered));
      end
   endtask

   initial begin
      int i;
      uhdl_common = 1'b0;
      rst_n       = 1'b0;
      errors      = 0;
      n_ops       = 0;
      limit       = 0;
      drive_req("S", 1'b0, 1'b0, 16'd0, 64'd0);
      drive_req("V", 1'b0, 1'b0, 16'd0, 64'd0);
      drive_req("M", 1'b0, 1'b0, 16'd0, 64'd0);
      drive_req("G", 1'b0, 1'b0, 16'd0, 64'd0);
      read_tests();
      limit = 16 + 20 * n_ops;               // Reset plus 20 cycles per line
      repeat (15) @(posedge uhdl_common);
      @(negedge uhdl_common);
      check_value("reset_outputs_low", 64'd0, 64'({sdram_ready, sdram_done, vram_cpu_ready,
                  vram_cpu_done, mcr_ready, mcr_done, vram_vga_ready}));
      @(posedge uhdl_common);
      #1;
      rst_n = 1'b1;
      i = 0;
      while (i < n_ops) begin
         if (op_code[i] == "C") begin
            run_group(i);
            i = i + 4;
         end else begin
            run_op(i, op_code[i] == "R" && op_port[i] != "G");
            i = i + 1;
         end
      end
      repeat (2) @(posedge uhdl_common);
      $display("lines: %0d, errors: %0d, timeouts: 0", n_ops, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: test_input.txt
# op port addr data expected, all hex; W writes, R reads and checks
# Four C lines in a row are issued together in one cycle as reads
W S 005 12345678 0
R S 005 0 12345678
W S 3ff 89abcdef 0
R S 3ff 0 89abcdef
W V 010 cafef00d 0
R G 010 0 cafef00d
W M 003 1abcd12345678 0
R M 003 0 1abcd12345678
W M 1ff 1ffffffffffff 0
R M 1ff 0 1ffffffffffff
W S 020 11111111 0
W V 020 22222222 0
W M 020 1333344444444 0
R S 020 0 11111111
R V 020 0 22222222
R M 020 0 1333344444444
W S 040 a5a5a5a5 0
W V 041 5a5a5a5a 0
W M 042 1f0f0f0f0f0f0 0
W V 043 deadbeef 0
C S 040 0 a5a5a5a5
C V 041 0 5a5a5a5a
C M 042 0 1f0f0f0f0f0f0
C G 043 0 deadbeef

// File: src.f
+incdir+.
uhdl_mem_pkg.sv
mem_beat_if.sv
req_port.sv
mem_arbiter.sv
sram_bank.sv
ram_controller.sv
tb_ram_controller.sv

// File: Makefile
TB := tb_ram_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module ram_controller
	verilator --lint-only --timing -f src.f --top-module $(TB)

sim:
	verilator --binary --timing -f src.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
